/* include/wbStage_config.svh */
// Write-back stage configuration
// Data width, register count and the instruction encodings
// that the write-back end decodes

`ifndef WB_STAGE_CONFIG_SVH
`define WB_STAGE_CONFIG_SVH

// Datapath sizing
`define WB_XLEN   32
`define WB_NREGS  32

// Load opcodes (I-type op field)
`define OP_LB     6'h20
`define OP_LH     6'h21
`define OP_LW     6'h23
`define OP_LBU    6'h24
`define OP_LHU    6'h25

// HI/LO move funct codes (R-type funct field)
`define FN_MFHI   6'h10
`define FN_MFLO   6'h12

`endif

/* src/wbPkg.sv */
// Write-back stage types
// Stage bundle from MEM2, result select, write enables,
// the two-view instruction word and the commit record

`include "wbStage_config.svh"

package wbPkg;

    // Result source for the GPR write
    typedef enum logic [1:0] {
        selAlu  = 2'd0,
        selMem  = 2'd1,                 // Load data
        selLink = 2'd2,                 // PC + 8
        selHiLo = 2'd3
    } wbSelT;

    typedef struct packed {
        logic gpr;
        logic hi;
        logic lo;
    } regsWrT;

    //------------------------------------------------------------
    // Instruction word, R-type and I-type views
    //------------------------------------------------------------
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;              // Picks HI or LO on a move
    } rTypeT;

    typedef struct packed {
        logic [5:0]  op;                // Picks load width and sign
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrU;

    typedef struct packed {
        logic                valid;
        logic [`WB_XLEN-1:0] pc;
        instrU               instr;
        logic [`WB_XLEN-1:0] aluOut;    // Also the load address
        logic [`WB_XLEN-1:0] dmOut;     // Raw aligned memory word
        logic [`WB_XLEN-1:0] outB;      // Source for mthi/mtlo
        wbSelT               wbSel;
        logic [4:0]          dst;
        regsWrT              regsWr;
        logic                storeReq;
    } stageBundleT;

    // One retired instruction
    typedef struct packed {
        logic [`WB_XLEN-1:0] pc;
        logic [4:0]          dst;
        logic [`WB_XLEN-1:0] data;
        logic                gprWe;
        logic                hiWe;
        logic                loWe;
        logic                storeReq;
    } commitT;

endpackage

/* src/wbPipeReg.sv */
// MEM2-to-WB pipeline register
// Holds one stage bundle; loads on write enable, clears to a
// bubble on flush, and holds otherwise

`timescale 1ns/1ps

module wbPipeReg (
    input  logic                clk,
    input  logic                arstN,
    input  logic                wbWr,       // Low while the pipeline stalls
    input  logic                wbFlush,    // Beats wbWr
    input  wbPkg::stageBundleT  d,
    output wbPkg::stageBundleT  q
);

    //------------------------------------------------------------
    // Bundle register
    //------------------------------------------------------------
    // All fields travel together, so a cleared bundle is
    // simply all zeros and valid drops with the rest
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (wbFlush) begin
            q <= '0;                        // Bubble
        end else if (wbWr) begin
            q <= d;
        end
    end

endmodule

/* src/wbControl.sv */
// Write-back control
// Drives the pipeline register enables from stall and flush,
// and gates commit and register writes so that each entry
// retires exactly once, however long it is held

`timescale 1ns/1ps

module wbControl (
    input  logic                clk,
    input  logic                arstN,
    input  logic                stall,
    input  logic                flush,
    input  wbPkg::stageBundleT  entry,      // Current WB content
    output logic                wbWr,
    output logic                wbFlush,
    output logic                gprWe,
    output logic                hiWe,
    output logic                loWe,
    output logic                commitValid
);

    logic done;                             // Held entry already retired

    //------------------------------------------------------------
    // Pipeline register control
    //------------------------------------------------------------
    assign wbWr    = ~stall;
    assign wbFlush = flush;

    // Set after the first commit of an entry, cleared whenever
    // a new entry (or a bubble) is loaded
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            done <= 1'b0;
        end else if (wbFlush || wbWr) begin
            done <= 1'b0;
        end else if (commitValid) begin
            done <= 1'b1;
        end
    end

    //------------------------------------------------------------
    // Commit and write gating
    //------------------------------------------------------------
    assign commitValid = entry.valid & ~done;

    // Register 0 is hard-wired to zero
    assign gprWe = commitValid & entry.regsWr.gpr & (entry.dst != 5'd0);
    assign hiWe  = commitValid & entry.regsWr.hi;
    assign loWe  = commitValid & entry.regsWr.lo;

    // A held entry commits in its first cycle only
    singleCommit: assert property (
        @(posedge clk) disable iff (!arstN)
        (commitValid && stall && !flush) |=> !commitValid
    ) else $error("commitValid repeated for a held entry");

endmodule

/* src/wbResultSelect.sv */
// Write-back result select
// Chooses the GPR write data from ALU, load, link or HI/LO,
// and extracts and extends sub-word loads from the raw word

`timescale 1ns/1ps

`include "wbStage_config.svh"

module wbResultSelect (
    input  wbPkg::stageBundleT    entry,
    input  logic [`WB_XLEN-1:0]   hiQ,
    input  logic [`WB_XLEN-1:0]   loQ,
    output logic [`WB_XLEN-1:0]   wbData
);

    import wbPkg::*;

    logic [5:0]          op;
    logic [5:0]          funct;
    logic [1:0]          byteOff;
    logic [`WB_XLEN-1:0] byteShift;
    logic [`WB_XLEN-1:0] halfShift;
    logic [7:0]          byteVal;
    logic [15:0]         halfVal;
    logic [`WB_XLEN-1:0] loadData;
    logic [`WB_XLEN-1:0] hiLoData;
    logic                isHalf;

    // Two views of the same word
    assign op    = entry.instr.iType.op;
    assign funct = entry.instr.rType.funct;

    //------------------------------------------------------------
    // Load extraction
    //------------------------------------------------------------
    assign byteOff   = entry.aluOut[1:0];      // Offset within the word
    assign byteShift = entry.dmOut >> {byteOff, 3'b000};
    assign halfShift = entry.dmOut >> {byteOff[1], 4'b0000};
    assign byteVal   = byteShift[7:0];
    assign halfVal   = halfShift[15:0];

    always_comb begin
        case (op)
            `OP_LB:  loadData = {{(`WB_XLEN-8){byteVal[7]}}, byteVal};
            `OP_LBU: loadData = {{(`WB_XLEN-8){1'b0}}, byteVal};
            `OP_LH:  loadData = {{(`WB_XLEN-16){halfVal[15]}}, halfVal};
            `OP_LHU: loadData = {{(`WB_XLEN-16){1'b0}}, halfVal};
            `OP_LW:  loadData = entry.dmOut;
            default: loadData = entry.dmOut;    // Not a load, word as is
        endcase
    end

    // mfhi reads HI, everything else on this path reads LO
    assign hiLoData = (funct == `FN_MFHI) ? hiQ : loQ;

    //------------------------------------------------------------
    // Result mux
    //------------------------------------------------------------
    always_comb begin
        case (entry.wbSel)
            selAlu:  wbData = entry.aluOut;
            selMem:  wbData = loadData;
            selLink: wbData = entry.pc + `WB_XLEN'd8;  // Past the delay slot
            selHiLo: wbData = hiLoData;
            default: wbData = entry.aluOut;
        endcase
    end

    // Halfword loads must be halfword aligned; MEM raises the
    // address error before such an entry could reach WB
    assign isHalf = (op == `OP_LH) || (op == `OP_LHU);

    always_comb begin
        if (entry.valid && (entry.wbSel == selMem) && isHalf) begin
            halfAligned: assert #0 (byteOff[0] == 1'b0)
                else $error("Halfword load at odd offset %0d", byteOff);
        end
    end

endmodule

/* src/archRegs.sv */
// Architectural registers
// 32-entry general register file with two combinational read
// ports that see a write pending in the same cycle, plus the
// HI and LO pair

`timescale 1ns/1ps

`include "wbStage_config.svh"

module archRegs (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  gprWe,
    input  logic                  hiWe,
    input  logic                  loWe,
    input  logic [4:0]            wrAddr,
    input  logic [`WB_XLEN-1:0]   wrData,
    input  logic [`WB_XLEN-1:0]   hiLoData,   // Shared source for HI and LO
    input  logic [4:0]            rdAddrA,
    input  logic [4:0]            rdAddrB,
    output logic [`WB_XLEN-1:0]   rdDataA,
    output logic [`WB_XLEN-1:0]   rdDataB,
    output logic [`WB_XLEN-1:0]   hiQ,
    output logic [`WB_XLEN-1:0]   loQ
);

    logic [`WB_XLEN-1:0] regFile [`WB_NREGS];
    logic [`WB_XLEN-1:0] hiReg;
    logic [`WB_XLEN-1:0] loReg;
    logic                wrPending;
    logic                hitA;
    logic                hitB;

    //------------------------------------------------------------
    // General registers
    //------------------------------------------------------------
    assign wrPending = gprWe && (wrAddr != 5'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wrPending) begin
            regFile[wrAddr] <= wrData;
        end
    end

    // Bypass the write that lands at the next edge
    assign hitA = wrPending && (rdAddrA == wrAddr);
    assign hitB = wrPending && (rdAddrB == wrAddr);

    assign rdDataA = (rdAddrA == 5'd0) ? '0 :
                     hitA              ? wrData : regFile[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? '0 :
                     hitB              ? wrData : regFile[rdAddrB];

    //------------------------------------------------------------
    // HI / LO
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (hiWe) hiReg <= hiLoData;
            if (loWe) loReg <= hiLoData;
        end
    end

    assign hiQ = hiWe ? hiLoData : hiReg;   // Pending mthi visible now
    assign loQ = loWe ? hiLoData : loReg;

endmodule

/* src/wbTop.sv */
// Write-back end of the integer pipeline
// Latches the MEM2 bundle, selects and extends the result,
// writes the GPRs and HI/LO, and reports one commit record
// per retired instruction

`timescale 1ns/1ps

`include "wbStage_config.svh"

module wbTop (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stall,
    input  logic                  flush,
    input  wbPkg::stageBundleT    mem2In,
    input  logic [4:0]            rdAddrA,
    input  logic [4:0]            rdAddrB,
    output logic [`WB_XLEN-1:0]   rdDataA,
    output logic [`WB_XLEN-1:0]   rdDataB,
    output wbPkg::commitT         commit,
    output logic                  commitValid
);

    import wbPkg::*;

    stageBundleT         wbQ;
    logic                wbWr;
    logic                wbFlush;
    logic                gprWe;
    logic                hiWe;
    logic                loWe;
    logic [`WB_XLEN-1:0] wbData;
    logic [`WB_XLEN-1:0] hiQ;
    logic [`WB_XLEN-1:0] loQ;

    //------------------------------------------------------------
    // Control and pipeline register
    //------------------------------------------------------------
    wbControl wbControl_i (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .entry       (wbQ),
        .wbWr        (wbWr),
        .wbFlush     (wbFlush),
        .gprWe       (gprWe),
        .hiWe        (hiWe),
        .loWe        (loWe),
        .commitValid (commitValid)
    );

    wbPipeReg wbPipeReg_i (
        .clk     (clk),
        .arstN   (arstN),
        .wbWr    (wbWr),
        .wbFlush (wbFlush),
        .d       (mem2In),
        .q       (wbQ)
    );

    //------------------------------------------------------------
    // Datapath
    //------------------------------------------------------------
    wbResultSelect wbResultSelect_i (
        .entry  (wbQ),
        .hiQ    (hiQ),
        .loQ    (loQ),
        .wbData (wbData)
    );

    archRegs archRegs_i (
        .clk      (clk),
        .arstN    (arstN),
        .gprWe    (gprWe),
        .hiWe     (hiWe),
        .loWe     (loWe),
        .wrAddr   (wbQ.dst),
        .wrData   (wbData),
        .hiLoData (wbQ.outB),               // mthi / mtlo operand
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .hiQ      (hiQ),
        .loQ      (loQ)
    );

    // Commit record, meaningful while commitValid is high
    assign commit = '{
        pc:       wbQ.pc,
        dst:      wbQ.dst,
        data:     wbData,
        gprWe:    gprWe,
        hiWe:     hiWe,
        loWe:     loWe,
        storeReq: wbQ.storeReq
    };

endmodule

/* tb/wbTop_tb.sv */
// Testbench for the write-back end
// Applies a table of MEM2 bundles with stall and flush, checks
// each commit record, and checks both read ports against a
// reference model of the GPRs, HI and LO

`timescale 1ns/1ps

`include "wbStage_config.svh"

module wbTop_tb;

    import wbPkg::*;

    typedef struct packed {
        stageBundleT         bundle;
        logic                stall;
        logic                flush;
        logic                expValid;
        logic                expGprWe;
        logic                chkData;      // Data is don't-care for mthi/mtlo
        logic [`WB_XLEN-1:0] expData;
    } rowT;

    localparam logic [`WB_XLEN-1:0] loadWord = 32'h8A7F_C3E1;

    logic                clk;
    logic                arstN;
    logic                stall;
    logic                flush;
    stageBundleT         mem2In;
    logic [4:0]          rdAddrA;
    logic [4:0]          rdAddrB;
    logic [`WB_XLEN-1:0] rdDataA;
    logic [`WB_XLEN-1:0] rdDataB;
    commitT              commit;
    logic                commitValid;

    rowT                 rows[$];
    string               rowNames[$];
    logic [`WB_XLEN-1:0] regModel [`WB_NREGS];
    logic [`WB_XLEN-1:0] hiModel;
    logic [`WB_XLEN-1:0] loModel;
    logic [`WB_XLEN-1:0] pcNext;
    integer              seed;
    int                  errorCount;
    int                  checkCount;
    int                  commitCount;
    int                  expCommits;
    logic                countOn;

    wbTop wbTop_i (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .mem2In      (mem2In),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .commit      (commit),
        .commitValid (commitValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Commits seen while the table runs
    always @(negedge clk) begin
        if (countOn && commitValid) begin
            commitCount++;
        end
    end

    task automatic checkValue(input string name, input logic [`WB_XLEN-1:0] expVal,
                              input logic [`WB_XLEN-1:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", name, expVal, actVal);
        end
    endtask

    //------------------------------------------------------------
    // Table construction
    //------------------------------------------------------------
    function automatic stageBundleT makeBundle(input wbSelT sel, input logic [5:0] op,
            input logic [5:0] funct, input logic [4:0] dst, input logic [31:0] aluOut,
            input logic [31:0] dmOut, input logic [31:0] outB, input logic [2:0] wr);
        stageBundleT b;
        b = '0;
        b.valid = 1'b1;
        b.pc = pcNext;
        pcNext = pcNext + 32'd4;
        b.instr.rType.funct = funct;
        b.instr.iType.op = op;
        b.aluOut = aluOut;
        b.dmOut = dmOut;
        b.outB = outB;
        b.wbSel = sel;
        b.dst = dst;
        b.regsWr = wr;                           // {gpr, hi, lo}
        return b;
    endfunction

    function automatic stageBundleT aluBundle(input logic [4:0] dst, input logic [31:0] value);
        return makeBundle(selAlu, 6'h00, 6'h21, dst, value, '0, '0, 3'b100);
    endfunction

    task automatic addRow(input string name, input stageBundleT b, input logic st,
            input logic fl, input logic expValid, input logic chkData,
            input logic [`WB_XLEN-1:0] expData);
        rowT r;
        r.bundle = b;
        r.stall = st;
        r.flush = fl;
        r.expValid = expValid;
        r.expGprWe = expValid & b.regsWr.gpr & (b.dst != 5'd0);
        r.chkData = chkData;
        r.expData = expData;
        rows.push_back(r);
        rowNames.push_back(name);
    endtask

    task automatic addLoad(input string name, input logic [5:0] op, input logic [1:0] off,
            input logic [4:0] dst, input logic [31:0] expData);
        stageBundleT b;
        b = makeBundle(selMem, op, 6'h00, dst, {30'h0400_0040, off}, loadWord, '0, 3'b100);
        addRow(name, b, 0, 0, 1, 1, expData);
    endtask

    task automatic buildTable();
        logic [31:0] rnd;
        logic [31:0] hiVal;
        logic [31:0] loVal;
        stageBundleT b;
        stageBundleT held;
        rnd = $random(seed);
        pcNext = {4'h0, rnd[27:2], 2'b00};
        rnd = $random(seed);
        addRow("aluR3", aluBundle(5'd3, rnd), 0, 0, 1, 1, rnd);
        b = makeBundle(selLink, 6'h03, 6'h00, 5'd31, '0, '0, '0, 3'b100);   // jal
        addRow("linkR31", b, 0, 0, 1, 1, b.pc + 32'd8);
        rnd = $random(seed);
        b = makeBundle(selMem, `OP_LW, 6'h00, 5'd4, 32'h1000_0200, rnd, '0, 3'b100);
        addRow("lwR4", b, 0, 0, 1, 1, rnd);
        // Sub-word loads, bytes 8A 7F C3 E1 from high to low
        addLoad("lb0", `OP_LB, 2'd0, 5'd10, 32'hFFFF_FFE1);
        addLoad("lb1", `OP_LB, 2'd1, 5'd11, 32'hFFFF_FFC3);
        addLoad("lb2", `OP_LB, 2'd2, 5'd12, 32'h0000_007F);
        addLoad("lb3", `OP_LB, 2'd3, 5'd13, 32'hFFFF_FF8A);
        addLoad("lbu0", `OP_LBU, 2'd0, 5'd14, 32'h0000_00E1);
        addLoad("lbu1", `OP_LBU, 2'd1, 5'd15, 32'h0000_00C3);
        addLoad("lbu2", `OP_LBU, 2'd2, 5'd16, 32'h0000_007F);
        addLoad("lbu3", `OP_LBU, 2'd3, 5'd17, 32'h0000_008A);
        addLoad("lh0", `OP_LH, 2'd0, 5'd18, 32'hFFFF_C3E1);
        addLoad("lh2", `OP_LH, 2'd2, 5'd19, 32'hFFFF_8A7F);
        addLoad("lhu0", `OP_LHU, 2'd0, 5'd20, 32'h0000_C3E1);
        addLoad("lhu2", `OP_LHU, 2'd2, 5'd21, 32'h0000_8A7F);
        // Each move-from directly follows its move-to
        hiVal = $random(seed);
        loVal = $random(seed);
        addRow("mthi", makeBundle(selAlu, 6'h00, 6'h11, 5'd0, '0, '0, hiVal, 3'b010),
               0, 0, 1, 0, '0);
        addRow("mfhi", makeBundle(selHiLo, 6'h00, `FN_MFHI, 5'd22, '0, '0, '0, 3'b100),
               0, 0, 1, 1, hiVal);
        addRow("mtlo", makeBundle(selAlu, 6'h00, 6'h13, 5'd0, '0, '0, loVal, 3'b001),
               0, 0, 1, 0, '0);
        addRow("mflo", makeBundle(selHiLo, 6'h00, `FN_MFLO, 5'd23, '0, '0, '0, 3'b100),
               0, 0, 1, 1, loVal);
        rnd = $random(seed);
        addRow("aluR0", aluBundle(5'd0, rnd), 0, 0, 1, 1, rnd);   // Commits, no write
        // A store retires with no register write
        rnd = $random(seed);
        b = makeBundle(selAlu, 6'h2B, 6'h00, 5'd0, rnd, '0, rnd, 3'b000);
        b.storeReq = 1'b1;
        addRow("swStore", b, 0, 0, 1, 0, '0);
        // R5 sits in WB while R6 waits under stall
        rnd = $random(seed);
        addRow("aluR5", aluBundle(5'd5, rnd), 0, 0, 1, 1, rnd);
        rnd = $random(seed);
        held = aluBundle(5'd6, rnd);
        for (int s = 0; s < 3; s++) begin
            addRow("stallR6", held, 1, 0, 0, 0, '0);
        end
        addRow("releaseR6", held, 0, 0, 1, 1, rnd);
        rnd = $random(seed);
        addRow("flushR9", aluBundle(5'd9, rnd), 0, 1, 0, 0, '0);
        rnd = $random(seed);
        held = aluBundle(5'd7, rnd);
        addRow("flushStallR7", held, 1, 1, 0, 0, '0);         // Flush beats stall
        addRow("replayR7", held, 0, 0, 1, 1, rnd);
        addRow("mfhiLater", makeBundle(selHiLo, 6'h00, `FN_MFHI, 5'd24, '0, '0, '0, 3'b100),
               0, 0, 1, 1, hiVal);
        addRow("mfloLater", makeBundle(selHiLo, 6'h00, `FN_MFLO, 5'd25, '0, '0, '0, 3'b100),
               0, 0, 1, 1, loVal);
    endtask

    //------------------------------------------------------------
    // Checking
    //------------------------------------------------------------
    task automatic checkRow(input int idx);
        rowT   r;
        string name;
        r = rows[idx];
        name = rowNames[idx];
        checkValue({name, " commitValid"}, r.expValid, commitValid);
        // Write enables stay low in every cycle that retires nothing
        checkValue({name, " gprWe"}, r.expGprWe, commit.gprWe);
        checkValue({name, " hiWe"}, r.expValid & r.bundle.regsWr.hi, commit.hiWe);
        checkValue({name, " loWe"}, r.expValid & r.bundle.regsWr.lo, commit.loWe);
        if (r.expValid) begin
            expCommits++;
            checkValue({name, " pc"}, r.bundle.pc, commit.pc);
            checkValue({name, " dst"}, r.bundle.dst, commit.dst);
            checkValue({name, " storeReq"}, r.bundle.storeReq, commit.storeReq);
            if (r.chkData) begin
                checkValue({name, " data"}, r.expData, commit.data);
            end
            if (r.bundle.wbSel == selHiLo) begin
                checkValue({name, " hilo"},
                           (r.bundle.instr.rType.funct == `FN_MFHI) ? hiModel : loModel,
                           commit.data);
            end
            if (r.expGprWe) begin
                regModel[r.bundle.dst] = r.expData;
            end
            if (r.bundle.regsWr.hi) begin
                hiModel = r.bundle.outB;
            end
            if (r.bundle.regsWr.lo) begin
                loModel = r.bundle.outB;
            end
        end
        // Port A points at this row's destination, so a write shows through bypass
        checkValue({name, " readA"}, regModel[rdAddrA], rdDataA);
        checkValue({name, " readB"}, regModel[rdAddrB], rdDataB);
    endtask

    task automatic runTable();
        logic [31:0] rnd;
        @(posedge clk);
        countOn = 1'b1;
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            rnd = $random(seed);
            if (i < rows.size()) begin
                mem2In <= rows[i].bundle;
                stall  <= rows[i].stall;
                flush  <= rows[i].flush;
            end else begin
                mem2In <= '0;                    // Trailing bubble
                stall  <= 1'b0;
                flush  <= 1'b0;
            end
            if (i > 0) begin
                rdAddrA <= rows[i-1].bundle.dst;
            end
            rdAddrB <= rnd[4:0];
            @(negedge clk);
            if (i > 0) begin
                checkRow(i - 1);                 // Row latched at this edge
            end
        end
        @(posedge clk);
        countOn = 1'b0;
    endtask

    task automatic checkAllRegs(input string tag);
        logic [4:0] addrB;
        for (int a = 0; a < `WB_NREGS; a++) begin
            addrB = 5'(`WB_NREGS - 1 - a);
            @(posedge clk);
            rdAddrA <= 5'(a);
            rdAddrB <= addrB;
            @(negedge clk);
            checkValue($sformatf("%s readA r%0d", tag, a), regModel[a], rdDataA);
            checkValue($sformatf("%s readB r%0d", tag, addrB), regModel[addrB], rdDataB);
        end
    endtask

    task automatic waitCommitIdle(input int maxCycles);
        int n;
        n = 0;
        @(negedge clk);
        while (commitValid && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (commitValid) begin
            errorCount++;
            $display("Timeout: commitValid still high after %0d cycles", maxCycles);
        end
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        seed = 97;
        errorCount = 0;
        checkCount = 0;
        commitCount = 0;
        expCommits = 0;
        countOn = 1'b0;
        arstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        mem2In = '0;
        rdAddrA = '0;
        rdAddrB = '0;
        hiModel = '0;
        loModel = '0;
        for (int r = 0; r < `WB_NREGS; r++) begin
            regModel[r] = '0;
        end
        buildTable();
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("reset commitValid", 1'b0, commitValid);
        checkAllRegs("reset");
        runTable();
        checkValue("commit count", expCommits, commitCount);
        waitCommitIdle(8);
        checkAllRegs("final");
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* wbStage.f */
+incdir+include
src/wbPkg.sv
src/wbPipeReg.sv
src/wbControl.sv
src/wbResultSelect.sv
src/archRegs.sv
src/wbTop.sv
tb/wbTop_tb.sv
